/* mpt_table_mem.sv */
//////////////////////////////////////////////////////////////////////
// Protection table memory
// Load write port and registered read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mptw_consts.svh"

module mpt_table_mem (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // Load port
    input  logic                        we_i,
    input  logic [`MPTW_TBL_ADDR_W-1:0] waddr_i,
    input  mptw_pkg::mpte_t             wdata_i,
    // Walk read port
    input  logic                        rd_en_i,
    input  logic [`MPTW_TBL_ADDR_W-1:0] rd_addr_i,
    output mptw_pkg::mpte_t             rdata_o
);

    mptw_pkg::mpte_t mem_q [`MPTW_TBL_DEPTH];
    mptw_pkg::mpte_t rdata_q;

    // Read data valid one cycle after the enable
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        if (rd_en_i) begin
            rdata_q <= mem_q[rd_addr_i];
        end
    end

    assign rdata_o = rdata_q;

    // Tables are only loaded while the walker is idle
    a_no_rw_overlap : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(we_i && rd_en_i));

endmodule

/* mptw_consts.svh */
//////////////////////////////////////////////////////////////////////
// MPT walker constants
// Widths, walk depth and table sizing shared by package and RTL
//////////////////////////////////////////////////////////////////////

`ifndef MPTW_CONSTS_SVH
`define MPTW_CONSTS_SVH

// Number of walk levels, root is level NUM_LEVELS-1
`define MPTW_NUM_LEVELS 2

// Per-level index field of the supervisor physical address
`define MPTW_IDX_W 4

// Page offset, untouched by the walk
`define MPTW_OFFSET_W 12

// Table memory geometry
`define MPTW_TBL_ADDR_W 8
`define MPTW_TBL_DEPTH 256

// Upper bound of the in-flight transaction counter
`define MPTW_MAX_INFLIGHT 15

`endif

/* mptw_pkg.sv */
//////////////////////////////////////////////////////////////////////
// MPT walker types
// Access encodings, fault causes, table entries and walk state
//////////////////////////////////////////////////////////////////////

`include "mptw_consts.svh"

package mptw_pkg;

    // Access type requested by the caller
    typedef enum logic [1:0] {
        ACCESS_READ  = 2'd0,
        ACCESS_WRITE = 2'd1,
        ACCESS_EXEC  = 2'd2
    } mpt_access_e;

    // Format fault reported by the walk
    typedef enum logic [1:0] {
        NO_ERROR      = 2'd0,
        ENTRY_INVALID = 2'd1,
        NOT_LEAF      = 2'd2
    } page_format_fault_e;

    // Supervisor physical address, idx[1] is the upper (root) field
    typedef struct packed {
        logic [`MPTW_NUM_LEVELS-1:0][`MPTW_IDX_W-1:0] idx;
        logic [`MPTW_OFFSET_W-1:0]                    offset;
    } spa_t;

    // One table entry
    typedef struct packed {
        logic                        valid;
        logic                        leaf;
        logic                        r;
        logic                        w;
        logic                        x;
        logic [2:0]                  rsvd;
        logic [`MPTW_TBL_ADDR_W-1:0] ptr;
    } mpte_t;

    // Walk state carried from stage to stage
    typedef struct packed {
        spa_t                        spa;
        mpt_access_e                 access;
        logic [`MPTW_TBL_ADDR_W-1:0] base;
        logic                        done;
        page_format_fault_e          format_error;
        logic                        access_fault;
    } mptw_txn_t;

    // Result at the walker boundary
    typedef struct packed {
        spa_t               spa;
        page_format_fault_e format_error;
        logic               access_fault;
    } mptw_result_t;

    // Table read request toward the arbiter
    typedef struct packed {
        logic                        valid;
        logic [`MPTW_TBL_ADDR_W-1:0] addr;
    } tbl_req_t;

endpackage

/* mptw_top.sv */
//////////////////////////////////////////////////////////////////////
// MPT walker top level
// Intake register, one walking stage per level, shared table memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mptw_consts.svh"

module mptw_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // Transaction port
    input  logic                         txn_valid_i,
    output logic                         txn_ready_o,
    input  mptw_pkg::spa_t               spa_i,
    input  logic [`MPTW_TBL_ADDR_W-1:0]  mmpt_base_i,
    input  mptw_pkg::mpt_access_e        access_i,
    // Table load port
    input  logic                         tbl_we_i,
    input  logic [`MPTW_TBL_ADDR_W-1:0]  tbl_waddr_i,
    input  mptw_pkg::mpte_t              tbl_wdata_i,
    // Result and status
    output mptw_pkg::mptw_result_t       result_o,
    output logic                         result_valid_o,
    output logic                         busy_o
);

    localparam int unsigned N = `MPTW_NUM_LEVELS;

    //////////////////////////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////////////////////////

    // Link N is intake output, link i is the output of level i
    mptw_pkg::mptw_txn_t link_txn   [N+1];
    logic                link_valid [N+1];
    logic                link_ready [N+1];

    // Table memory side
    mptw_pkg::tbl_req_t          tbl_req [N];
    logic [N-1:0]                tbl_gnt;
    logic                        rd_en;
    logic [`MPTW_TBL_ADDR_W-1:0] rd_addr;
    mptw_pkg::mpte_t             rdata;

    walk_intake u_intake (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .txn_valid_i    ( txn_valid_i    ),
        .txn_ready_o    ( txn_ready_o    ),
        .spa_i          ( spa_i          ),
        .mmpt_base_i    ( mmpt_base_i    ),
        .access_i       ( access_i       ),
        .txn_o          ( link_txn[N]    ),
        .txn_valid_o    ( link_valid[N]  ),
        .txn_ready_i    ( link_ready[N]  ),
        .result_valid_i ( result_valid_o ),
        .busy_o         ( busy_o         )
    );

    // Root stage first, level 0 last
    for (genvar lvl = 0; lvl < N; lvl++) begin : gen_stage
        walking_stage #(
            .WALK_LEVEL ( lvl )
        ) u_stage (
            .clk_i       ( clk_i             ),
            .rst_n_i     ( rst_n_i           ),
            .txn_i       ( link_txn[lvl+1]   ),
            .txn_valid_i ( link_valid[lvl+1] ),
            .txn_ready_o ( link_ready[lvl+1] ),
            .txn_o       ( link_txn[lvl]     ),
            .txn_valid_o ( link_valid[lvl]   ),
            .txn_ready_i ( link_ready[lvl]   ),
            .tbl_req_o   ( tbl_req[lvl]      ),
            .tbl_gnt_i   ( tbl_gnt[lvl]      ),
            .tbl_rdata_i ( rdata             )
        );
    end

    table_mem_arbiter u_arb (
        .clk_i     ( clk_i   ),
        .rst_n_i   ( rst_n_i ),
        .req_i     ( tbl_req ),
        .gnt_o     ( tbl_gnt ),
        .rd_en_o   ( rd_en   ),
        .rd_addr_o ( rd_addr )
    );

    mpt_table_mem u_mem (
        .clk_i     ( clk_i       ),
        .rst_n_i   ( rst_n_i     ),
        .we_i      ( tbl_we_i    ),
        .waddr_i   ( tbl_waddr_i ),
        .wdata_i   ( tbl_wdata_i ),
        .rd_en_i   ( rd_en       ),
        .rd_addr_i ( rd_addr     ),
        .rdata_o   ( rdata       )
    );

    // Results have no back-pressure
    assign link_ready[0]           = 1'b1;
    assign result_valid_o          = link_valid[0];
    assign result_o.spa            = link_txn[0].spa;
    assign result_o.format_error   = link_txn[0].format_error;
    assign result_o.access_fault   = link_txn[0].access_fault;

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile the walker and its testbench with Verilator, then run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_mptw_top -o tb_mptw_top &&
./obj_dir/tb_mptw_top || { echo "simulation failed"; exit 1; }

/* sources.f */
+incdir+.
mptw_pkg.sv
mpt_table_mem.sv
table_mem_arbiter.sv
walking_stage.sv
walk_intake.sv
mptw_top.sv
tb_mptw_top.sv

/* table_mem_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// Table memory arbiter
// Round-robin grant of the single table read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mptw_consts.svh"

module table_mem_arbiter (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  mptw_pkg::tbl_req_t              req_i [`MPTW_NUM_LEVELS],
    output logic [`MPTW_NUM_LEVELS-1:0]     gnt_o,
    output logic                            rd_en_o,
    output logic [`MPTW_TBL_ADDR_W-1:0]     rd_addr_o
);

    localparam int unsigned N     = `MPTW_NUM_LEVELS;
    localparam int unsigned PTR_W = (N > 1) ? $clog2(N) : 1;

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] sel;
    logic             found;

    // Search from the pointer upward with wrap, first requester wins
    always_comb begin
        int unsigned cand;
        found = 1'b0;
        sel   = '0;
        for (int unsigned k = 0; k < N; k++) begin
            cand = (32'(ptr_q) + k) % N;
            if (!found && req_i[cand].valid) begin
                found = 1'b1;
                sel   = PTR_W'(cand);
            end
        end
    end

    always_comb begin
        gnt_o = '0;
        if (found) begin
            gnt_o[sel] = 1'b1;
        end
    end

    // Granted address goes straight to the memory
    assign rd_en_o   = found;
    assign rd_addr_o = req_i[sel].addr;

    // Pointer moves past the winner
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (found) begin
            if (32'(sel) == N - 1) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= sel + 1'b1;
            end
        end
    end

    a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(gnt_o));

endmodule

/* tb_mptw_checks.svh */
//////////////////////////////////////////////////////////////////////
// MPT walker testbench helpers
// Reference walk, xorshift generator and typed compare tasks
//////////////////////////////////////////////////////////////////////

`ifndef TB_MPTW_CHECKS_SVH
`define TB_MPTW_CHECKS_SVH

// Xorshift step, 13/17/5 shifts
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Permission bit selected by the access type
function automatic logic perm_bit(input mptw_pkg::mpte_t e, input mptw_pkg::mpt_access_e acc);
    case (acc)
        mptw_pkg::ACCESS_READ:  return e.r;
        mptw_pkg::ACCESS_WRITE: return e.w;
        mptw_pkg::ACCESS_EXEC:  return e.x;
        default:                return 1'b0;
    endcase
endfunction

// Expected result of a walk over the table image, root level first
function automatic mptw_pkg::mptw_result_t mptw_ref(input mptw_pkg::spa_t spa,
        input logic [`MPTW_TBL_ADDR_W-1:0] base, input mptw_pkg::mpt_access_e acc);
    mptw_pkg::mptw_result_t      res;
    mptw_pkg::mpte_t             e;
    logic [`MPTW_TBL_ADDR_W-1:0] cur;
    logic [`MPTW_TBL_ADDR_W-1:0] addr;
    logic                        stop;
    res.spa          = spa;
    res.format_error = mptw_pkg::NO_ERROR;
    res.access_fault = 1'b0;
    cur              = base;
    stop             = 1'b0;
    for (int lvl = `MPTW_NUM_LEVELS - 1; lvl >= 0; lvl--) begin
        if (!stop) begin
            // Entry address wraps in 8 bits
            addr = cur + `MPTW_TBL_ADDR_W'(spa.idx[lvl]);
            e    = tbl_img[addr];
            if (!e.valid) begin
                res.format_error = mptw_pkg::ENTRY_INVALID;
                stop             = 1'b1;
            end else if (e.leaf) begin
                res.access_fault = !perm_bit(e, acc);
                stop             = 1'b1;
            end else if (lvl == 0) begin
                res.format_error = mptw_pkg::NOT_LEAF;
                stop             = 1'b1;
            end else begin
                cur = e.ptr;
            end
        end
    end
    return res;
endfunction

task automatic check_result(input string name, input mptw_pkg::mptw_result_t got,
        input mptw_pkg::mptw_result_t exp);
    if (got !== exp) begin
        $display("FAILED at %0t ns: %s got spa=%h fmt=%0d fault=%b, expected spa=%h fmt=%0d fault=%b",
                 $time, name, got.spa, got.format_error, got.access_fault,
                 exp.spa, exp.format_error, exp.access_fault);
        stop_run("walk result mismatch");
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAILED at %0t ns: %s got %b, expected %b", $time, name, got, exp);
        stop_run("status bit mismatch");
    end
endtask

`endif

/* tb_mptw_top.sv */
//////////////////////////////////////////////////////////////////////
// MPT walker testbench
// Directed and random walks checked in order against a reference
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mptw_consts.svh"

module tb_mptw_top;

    // Directed walks are 24 permission, 3 fault and 3 superpage cases
    localparam int NUM_RAND    = 200;
    localparam int NUM_TXN     = 30 + NUM_RAND;
    localparam int LOAD_CYCLES = `MPTW_TBL_DEPTH + 64;
    localparam int WATCHDOG_NS = (NUM_TXN * 40 + LOAD_CYCLES) * 40;

    logic                            clk_i = 1'b0;
    logic                            rst_n_i;
    logic                            txn_valid_i;
    logic                            txn_ready_o;
    mptw_pkg::spa_t                  spa_i;
    logic [`MPTW_TBL_ADDR_W-1:0]     mmpt_base_i;
    mptw_pkg::mpt_access_e           access_i;
    logic                            tbl_we_i;
    logic [`MPTW_TBL_ADDR_W-1:0]     tbl_waddr_i;
    mptw_pkg::mpte_t                 tbl_wdata_i;
    mptw_pkg::mptw_result_t          result_o;
    logic                            result_valid_o;
    logic                            busy_o;

    // Testbench copy of the table and expected results in order
    mptw_pkg::mpte_t                 tbl_img [`MPTW_TBL_DEPTH];
    mptw_pkg::mptw_result_t          exp_q [$];
    int                              n_accepted = 0;
    int                              n_results  = 0;
    logic [31:0]                     rng = 32'h50d0;

    task automatic stop_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "walker testbench stopped");
    endtask

`include "tb_mptw_checks.svh"

    mptw_top DUT (.*);

    always #20 clk_i = ~clk_i;

    function automatic mptw_pkg::mpte_t make_entry(input logic v, input logic leaf,
            input logic [2:0] rwx, input logic [7:0] ptr);
        mptw_pkg::mpte_t e;
        e = '{valid: v, leaf: leaf, r: rwx[2], w: rwx[1], x: rwx[0], rsvd: 3'b000, ptr: ptr};
        return e;
    endfunction

    function automatic mptw_pkg::spa_t make_spa(input logic [3:0] i1, input logic [3:0] i0,
            input logic [11:0] off);
        mptw_pkg::spa_t s;
        s.idx[1] = i1;
        s.idx[0] = i0;
        s.offset = off;
        return s;
    endfunction

    // Load one entry through the write port, walker must be idle
    task automatic write_entry(input logic [7:0] addr, input mptw_pkg::mpte_t e);
        if (busy_o) stop_run("table write attempted while the walker is busy");
        tbl_img[addr] = e;
        tbl_we_i      = 1'b1;
        tbl_waddr_i   = addr;
        tbl_wdata_i   = e;
        @(posedge clk_i);
        #2;
        tbl_we_i      = 1'b0;
    endtask

    // Hold the request until accepted, ready sampled mid-cycle
    task automatic send_txn(input mptw_pkg::spa_t spa, input logic [7:0] base,
            input mptw_pkg::mpt_access_e acc);
        logic taken;
        txn_valid_i = 1'b1;
        spa_i       = spa;
        mmpt_base_i = base;
        access_i    = acc;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = txn_ready_o;
            @(posedge clk_i);
        end
        exp_q.push_back(mptw_ref(spa, base, acc));
        n_accepted++;
        #2;
        txn_valid_i = 1'b0;
    endtask

    // Drain all outstanding walks, then busy must be low
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 40 * NUM_TXN) begin
            @(negedge clk_i);
            cycles++;
        end
        if (exp_q.size() != 0) stop_run("expected results never came out of the walker");
        @(negedge clk_i);
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("txn_ready_o", txn_ready_o, 1'b1);
        check_bit("result_valid_o", result_valid_o, 1'b0);
        @(posedge clk_i);
        #2;
    endtask

    ///////////////////////////////////////////////////////////////////
    // Result compare
    ///////////////////////////////////////////////////////////////////

    // Busy reflects accepted minus retired, result popped in order
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            check_bit("busy_o", busy_o, n_accepted != n_results);
            if (result_valid_o) begin
                if (exp_q.size() == 0) begin
                    stop_run("result_valid_o with no transaction outstanding");
                end else begin
                    check_result("result_o", result_o, exp_q.pop_front());
                    n_results++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_run("watchdog expired before all transactions finished");
    end

    initial begin : main
        mptw_pkg::mpt_access_e acc;
        txn_valid_i = 1'b0;
        spa_i       = '0;
        mmpt_base_i = '0;
        access_i    = mptw_pkg::ACCESS_READ;
        tbl_we_i    = 1'b0;
        tbl_waddr_i = '0;
        tbl_wdata_i = '0;
        rst_n_i     = 1'b0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_bit("txn_ready_o", txn_ready_o, 1'b1);
        check_bit("result_valid_o", result_valid_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);
        @(posedge clk_i);
        #2;

        // Root at 0x00, leaf table at 0x20 holds every rwx mix
        write_entry(8'h01, make_entry(1'b1, 1'b0, 3'b000, 8'h20));
        for (int k = 0; k < 8; k++) write_entry(8'h20 + 8'(k), make_entry(1'b1, 1'b1, 3'(k), 8'h00));
        // Fault cases hang off root entries 2 and 3, no permission granted
        write_entry(8'h02, make_entry(1'b0, 1'b1, 3'b000, 8'h00));
        write_entry(8'h03, make_entry(1'b1, 1'b0, 3'b111, 8'h40));
        write_entry(8'h40, make_entry(1'b0, 1'b1, 3'b000, 8'h00));
        write_entry(8'h41, make_entry(1'b1, 1'b0, 3'b000, 8'h55));
        // Superpage at root entry 4, write denied
        write_entry(8'h04, make_entry(1'b1, 1'b1, 3'b101, 8'h00));

        for (int a = 0; a < 3; a++) begin
            acc = mptw_pkg::mpt_access_e'(a);
            for (int k = 0; k < 8; k++) send_txn(make_spa(4'd1, 4'(k), 12'h123), 8'h00, acc);
        end
        send_txn(make_spa(4'd2, 4'd0, 12'h0a0), 8'h00, mptw_pkg::ACCESS_WRITE);
        send_txn(make_spa(4'd3, 4'd0, 12'h0b0), 8'h00, mptw_pkg::ACCESS_WRITE);
        send_txn(make_spa(4'd3, 4'd1, 12'h0c0), 8'h00, mptw_pkg::ACCESS_WRITE);
        for (int a = 0; a < 3; a++) begin
            send_txn(make_spa(4'd4, 4'd9, 12'hfff), 8'h00, mptw_pkg::mpt_access_e'(a));
        end
        wait_idle();

        // Random table, then a back-to-back stream with contention
        for (int a = 0; a < `MPTW_TBL_DEPTH; a++) begin
            rng = xorshift32(rng);
            write_entry(8'(a), mptw_pkg::mpte_t'(rng[15:0]));
        end
        for (int n = 0; n < NUM_RAND; n++) begin
            rng = xorshift32(rng);
            acc = mptw_pkg::mpt_access_e'(2'(rng[31:28] % 4'd3));
            send_txn(mptw_pkg::spa_t'(rng[19:0]), rng[27:20], acc);
        end
        wait_idle();

        if (exp_q.size() == 0 && n_results == n_accepted && n_accepted == NUM_TXN) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_run("result count does not match accepted transactions");
        end
    end

endmodule

/* walk_intake.sv */
//////////////////////////////////////////////////////////////////////
// Walk intake
// Registers accepted transactions and tracks work in flight
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mptw_consts.svh"

module walk_intake (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        txn_valid_i,
    output logic                        txn_ready_o,
    input  mptw_pkg::spa_t              spa_i,
    input  logic [`MPTW_TBL_ADDR_W-1:0] mmpt_base_i,
    input  mptw_pkg::mpt_access_e       access_i,
    output mptw_pkg::mptw_txn_t         txn_o,
    output logic                        txn_valid_o,
    input  logic                        txn_ready_i,
    input  logic                        result_valid_i,
    output logic                        busy_o
);

    localparam int unsigned CNT_W = $clog2(`MPTW_MAX_INFLIGHT + 1);

    logic                accept;
    logic                valid_q;
    mptw_pkg::mptw_txn_t txn_q;
    logic [CNT_W-1:0]    inflight_q;

    // Entry register frees when empty or when the root stage takes it
    assign txn_ready_o = !valid_q || txn_ready_i;
    assign accept      = txn_valid_i && txn_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (txn_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // Initial walk state, starts at the root table
    always_ff @(posedge clk_i) begin
        if (accept) begin
            txn_q.spa          <= spa_i;
            txn_q.access       <= access_i;
            txn_q.base         <= mmpt_base_i;
            txn_q.done         <= 1'b0;
            txn_q.format_error <= mptw_pkg::NO_ERROR;
            txn_q.access_fault <= 1'b0;
        end
    end

    assign txn_o       = txn_q;
    assign txn_valid_o = valid_q;

    //////////////////////////////////////////////////////////////////////
    // In-flight counter
    //////////////////////////////////////////////////////////////////////

    // Up on accept, down on result, both at once cancel out
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inflight_q <= '0;
        end else if (accept && !result_valid_i) begin
            inflight_q <= inflight_q + 1'b1;
        end else if (!accept && result_valid_i) begin
            inflight_q <= inflight_q - 1'b1;
        end
    end

    assign busy_o = (inflight_q != '0);

    // Pipeline depth must keep the count below its limit
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (inflight_q == CNT_W'(`MPTW_MAX_INFLIGHT)) |-> !(accept && !result_valid_i));

    // A result never appears without a transaction in flight
    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (inflight_q == '0) |-> !result_valid_i);

endmodule

/* walking_stage.sv */
//////////////////////////////////////////////////////////////////////
// Walking stage
// Fetches the entry for one level, parses it and forwards the walk
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mptw_consts.svh"

module walking_stage #(
    parameter int unsigned WALK_LEVEL = 0
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  mptw_pkg::mptw_txn_t txn_i,
    input  logic                txn_valid_i,
    output logic                txn_ready_o,
    output mptw_pkg::mptw_txn_t txn_o,
    output logic                txn_valid_o,
    input  logic                txn_ready_i,
    output mptw_pkg::tbl_req_t  tbl_req_o,
    input  logic                tbl_gnt_i,
    input  mptw_pkg::mpte_t     tbl_rdata_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_OUT
    } state_e;

    state_e              state_q;
    mptw_pkg::mptw_txn_t txn_q;
    mptw_pkg::mptw_txn_t parsed;
    logic                capture;
    logic                perm_ok;

    // One transaction held at a time
    assign txn_ready_o = (state_q == ST_IDLE);
    assign capture     = txn_valid_i && txn_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                // Finished walks skip the memory
                ST_IDLE: if (capture) state_q <= txn_i.done ? ST_OUT : ST_REQ;
                ST_REQ:  if (tbl_gnt_i) state_q <= ST_WAIT;
                // Read data lands one cycle after grant
                ST_WAIT: state_q <= ST_OUT;
                ST_OUT:  if (txn_ready_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            txn_q <= txn_i;
        end else if (state_q == ST_WAIT) begin
            txn_q <= parsed;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Entry request and parsing
    //////////////////////////////////////////////////////////////////////

    // Entry address wraps in 8-bit arithmetic
    assign tbl_req_o.valid = (state_q == ST_REQ);
    assign tbl_req_o.addr  = txn_q.base
                           + `MPTW_TBL_ADDR_W'(txn_q.spa.idx[WALK_LEVEL]);

    always_comb begin
        case (txn_q.access)
            mptw_pkg::ACCESS_READ:  perm_ok = tbl_rdata_i.r;
            mptw_pkg::ACCESS_WRITE: perm_ok = tbl_rdata_i.w;
            mptw_pkg::ACCESS_EXEC:  perm_ok = tbl_rdata_i.x;
            default:                perm_ok = 1'b0;
        endcase
    end

    always_comb begin
        parsed      = txn_q;
        parsed.done = 1'b1;
        if (!tbl_rdata_i.valid) begin
            parsed.format_error = mptw_pkg::ENTRY_INVALID;
        end else if (tbl_rdata_i.leaf) begin
            // Leaf at any level ends the walk, superpage above level 0
            parsed.access_fault = !perm_ok;
        end else if (WALK_LEVEL == 0) begin
            parsed.format_error = mptw_pkg::NOT_LEAF;
        end else begin
            // Descend to next table
            parsed.base = tbl_rdata_i.ptr;
            parsed.done = 1'b0;
        end
    end

    assign txn_o       = txn_q;
    assign txn_valid_o = (state_q == ST_OUT);

    // Arbiter grant must retire the request on the next cycle
    a_req_drop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tbl_req_o.valid && tbl_gnt_i) |=> !tbl_req_o.valid);

endmodule
